/* rtl/i3c_ccc_pkg.sv */
// ======================================================================
// shared definitions for the i3c hdr-ddr ccc engine
// timing constants, frame geometry, handler states, datapath structs
// and the direct/broadcast ccc lookup used by the frame fsm
// ======================================================================

package i3c_ccc_pkg;

  localparam int SCL_DIV      = 4;   // sys clocks per scl half period (one ddr slot)
  localparam int DIV_W        = $clog2(SCL_DIV);
  localparam int CMD_BITS     = 20;  // preamble 01 + 16 payload + 2 parity
  localparam int DATA_BITS    = 18;  // 16 payload + 2 parity
  localparam int ACK_BITS     = 2;   // target preamble
  localparam int RESTART_BITS = 4;
  localparam int BYTE_BITS    = 8;
  localparam int PAR_BITS     = 2;

  // cumulative slot numbers where each sub-phase of a word ends
  localparam int CMD_PRE_END  = CMD_BITS - PAR_BITS - 2 * BYTE_BITS;  // 2
  localparam int CMD_HI_END   = CMD_BITS - PAR_BITS - BYTE_BITS;      // 10
  localparam int CMD_LO_END   = CMD_BITS - PAR_BITS;                  // 18
  localparam int DATA_HI_END  = BYTE_BITS;                            // 8
  localparam int DATA_LO_END  = DATA_BITS - PAR_BITS;                 // 16

  localparam logic [6:0] BCAST_ADDR = 7'h7E;

  typedef enum logic [3:0] {
    IDLE,
    PRE_CMD,
    CMD_HI,
    CMD_LO,
    PARITY_CMD,
    PRE_ACK,
    DATA_HI,
    DATA_LO,
    PARITY_DATA,
    RESTART_PATTERN,
    ERROR
  } ccc_state_e;

  typedef struct packed {
    logic [7:0] hi;  // sent first
    logic [7:0] lo;
  } ddr_word_t;

  typedef struct packed {
    logic tx_load;   // capture a new word image
    logic tx_en;     // serializer owns sda for the coming slot
    logic rx_en;     // preamble sampler listening
    logic restart;   // alternating restart bits
    logic pre_only;  // word starts with the 01 command preamble
  } ccc_ctrl_t;

  // thirteen required ccc codes, anything unknown is broadcast
  function automatic logic is_direct_ccc(input logic [7:0] code);
    case (code)
      8'h80, 8'h81: return 1'b1;                  // enec / disec
      8'h89, 8'h8A, 8'h8B, 8'h8C: return 1'b1;    // set/get mwl, mrl
      8'h9A, 8'h90: return 1'b1;                  // rstact / getstatus
      8'h00, 8'h01, 8'h09, 8'h0A: return 1'b0;    // broadcast enec..setmrl
      8'h2A: return 1'b0;                         // broadcast rstact
      8'h1F: return 1'b0;                         // dummy ccc, end procedure
      default: return 1'b0;
    endcase
  endfunction

endpackage

/* rtl/scl_edge_gen.sv */
// ======================================================================
// scl timer for the ddr engine
// divides the system clock by SCL_DIV while enabled, toggles scl and
// flags every toggle with a one cycle strobe, parks scl high when off
// ======================================================================
`timescale 1ns/1ps

module scl_edge_gen (
  input  logic i_sys_clk,
  input  logic i_sys_rst,
  input  logic i_en,
  output logic o_scl,
  output logic o_pos_edge,
  output logic o_neg_edge
);
  import i3c_ccc_pkg::*;

  logic [DIV_W-1:0] div_q;  // half period timer

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      div_q      <= '0;
      o_scl      <= 1'b1;
      o_pos_edge <= 1'b0;
      o_neg_edge <= 1'b0;
    end else if (!i_en) begin
      div_q      <= '0;
      o_scl      <= 1'b1;  // bus idle level
      o_pos_edge <= 1'b0;
      o_neg_edge <= 1'b0;
    end else if (div_q == DIV_W'(SCL_DIV - 1)) begin
      div_q      <= '0;
      o_scl      <= ~o_scl;
      o_pos_edge <= ~o_scl;  // scl going high
      o_neg_edge <= o_scl;   // scl going low
    end else begin
      div_q      <= div_q + 1'b1;
      o_pos_edge <= 1'b0;
      o_neg_edge <= 1'b0;
    end
  end

endmodule

/* rtl/ddr_bit_cnt.sv */
// ======================================================================
// ddr slot counter
// counts scl edge strobes inside the current word, cleared by the
// frame fsm at each word boundary, saturates instead of wrapping
// ======================================================================
`timescale 1ns/1ps

module ddr_bit_cnt (
  input  logic       i_sys_clk,
  input  logic       i_sys_rst,
  input  logic       i_clear,
  input  logic       i_step,
  output logic [4:0] o_bit_number
);

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      o_bit_number <= '0;
    end else if (i_clear) begin
      // a boundary strobe already opens slot one of the new word
      o_bit_number <= i_step ? 5'd1 : 5'd0;
    end else if (i_step && (o_bit_number != 5'd31)) begin
      o_bit_number <= o_bit_number + 5'd1;
    end
  end

endmodule

/* rtl/ccc_handler.sv */
// ======================================================================
// ccc frame fsm
// on a start strobe sends the 7E command word, checks the target ack
// preamble and sends the ccc data word; broadcast codes finish with
// done, direct codes add a restart pattern and finish with semi done
// ======================================================================
`timescale 1ns/1ps

module ccc_handler (
  input  logic                   i_sys_clk,
  input  logic                   i_sys_rst,
  input  logic                   i_engine_en,
  input  logic [7:0]             i_ccc_value,
  input  logic                   i_step,
  input  logic [4:0]             i_bit_number,
  input  logic                   i_ack_done,
  input  logic                   i_abort,
  output logic                   o_scl_en,
  output logic                   o_bit_clear,
  output i3c_ccc_pkg::ccc_ctrl_t o_ctrl,
  output i3c_ccc_pkg::ddr_word_t o_tx_word,
  output logic                   o_engine_done,
  output logic                   o_engine_semi_done,
  output logic                   o_engine_err
);
  import i3c_ccc_pkg::*;

  ccc_state_e state_q;
  ccc_state_e state_d;
  logic [7:0] ccc_q;     // code captured at start
  logic       direct_q;  // 1 direct, 0 broadcast
  ddr_word_t  cmd_word;
  ddr_word_t  data_word;
  logic       start;

  assign start = (state_q == IDLE) && i_engine_en;  // starts mid frame are dropped

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      state_q            <= IDLE;
      direct_q           <= 1'b0;
      o_engine_done      <= 1'b0;
      o_engine_semi_done <= 1'b0;
      o_engine_err       <= 1'b0;
    end else begin
      state_q            <= state_d;
      if (start) direct_q <= is_direct_ccc(i_ccc_value);
      o_engine_done      <= (state_q == PARITY_DATA) && (state_d == IDLE);
      o_engine_semi_done <= (state_q == RESTART_PATTERN) && (state_d == IDLE);
      o_engine_err       <= (state_d == ERROR) && (state_q != ERROR);
    end
  end

  always_ff @(posedge i_sys_clk) begin
    if (start) ccc_q <= i_ccc_value;
  end

  // phases end on the strobe after their last slot, slot counts are per word
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:            if (start) state_d = PRE_CMD;
      PRE_CMD:         if (i_step && i_bit_number == 5'(CMD_PRE_END)) state_d = CMD_HI;
      CMD_HI:          if (i_step && i_bit_number == 5'(CMD_HI_END)) state_d = CMD_LO;
      CMD_LO:          if (i_step && i_bit_number == 5'(CMD_LO_END)) state_d = PARITY_CMD;
      PARITY_CMD:      if (i_step && i_bit_number == 5'(CMD_BITS)) state_d = PRE_ACK;
      PRE_ACK: begin
        if (i_step && i_bit_number == 5'(ACK_BITS) && i_ack_done) begin
          state_d = i_abort ? ERROR : DATA_HI;  // second preamble bit 1 means abort
        end
      end
      DATA_HI:         if (i_step && i_bit_number == 5'(DATA_HI_END)) state_d = DATA_LO;
      DATA_LO:         if (i_step && i_bit_number == 5'(DATA_LO_END)) state_d = PARITY_DATA;
      PARITY_DATA: begin
        if (i_step && i_bit_number == 5'(DATA_BITS)) begin
          state_d = direct_q ? RESTART_PATTERN : IDLE;
        end
      end
      RESTART_PATTERN: if (i_step && i_bit_number == 5'(RESTART_BITS)) state_d = IDLE;
      ERROR:           state_d = IDLE;  // one cycle to settle the bus
      default:         state_d = IDLE;
    endcase
  end

  // tx side looks at the slot about to start, rx side at the slot just ended
  always_comb begin
    o_ctrl          = '0;
    o_ctrl.tx_en    = state_d inside {PRE_CMD, CMD_HI, CMD_LO, PARITY_CMD,
                                      DATA_HI, DATA_LO, PARITY_DATA, RESTART_PATTERN};
    o_ctrl.tx_load  = (state_d != state_q) && (state_d inside {PRE_CMD, DATA_HI});
    o_ctrl.rx_en    = (state_q == PRE_ACK);
    o_ctrl.restart  = (state_d == RESTART_PATTERN);
    o_ctrl.pre_only = (state_d == PRE_CMD);
  end

  assign o_bit_clear = (state_d != state_q) &&
                       (state_d inside {PRE_CMD, PRE_ACK, DATA_HI, RESTART_PATTERN});
  assign o_scl_en    = (state_q != IDLE) || (state_d != IDLE);  // hold until last slot closes

  // command word: rnw 0 + reserved, then 7E + parity adjust 0
  assign cmd_word.hi  = 8'h00;
  assign cmd_word.lo  = {BCAST_ADDR, 1'b0};
  assign data_word.hi = ccc_q;
  assign data_word.lo = 8'h00;  // no defining byte
  assign o_tx_word    = o_ctrl.pre_only ? cmd_word : data_word;

endmodule

/* rtl/ddr_tx_ser.sv */
// ======================================================================
// ddr word serializer
// builds the shift image from a 16-bit payload plus its two parity
// bits, with the 01 preamble in front of a command word, and puts one
// bit on sda per scl edge; also drives the 1,0 restart pattern
// ======================================================================
`timescale 1ns/1ps

module ddr_tx_ser (
  input  logic                   i_sys_clk,
  input  logic                   i_sys_rst,
  input  i3c_ccc_pkg::ccc_ctrl_t i_ctrl,
  input  i3c_ccc_pkg::ddr_word_t i_word,
  input  logic                   i_step,
  output logic                   o_sda,
  output logic                   o_sda_oe
);
  import i3c_ccc_pkg::*;

  logic [15:0]         payload;
  logic                par_odd;   // bits 15,13..1
  logic                par_even;  // bits 14,12..0, sent inverted
  logic [CMD_BITS-1:0] img;
  logic [CMD_BITS-1:0] src;
  logic [CMD_BITS-1:0] sh_q;      // msb is next bit out
  logic                rst_bit_q;

  assign payload = i_word;

  always_comb begin
    par_odd  = 1'b0;
    par_even = 1'b0;
    for (int i = 0; i < 16; i += 2) begin
      par_even ^= payload[i];
      par_odd  ^= payload[i+1];
    end
  end

  // data image is left aligned, the two trailing zeros are never shifted out
  assign img = i_ctrl.pre_only ? {2'b01, payload, par_odd, ~par_even}
                               : {payload, par_odd, ~par_even, 2'b00};
  assign src = i_ctrl.tx_load ? img : sh_q;  // load and first shift can share a strobe

  always_ff @(posedge i_sys_clk) begin
    if (i_step && i_ctrl.tx_en) sh_q <= {src[CMD_BITS-2:0], 1'b0};
    else if (i_ctrl.tx_load)    sh_q <= img;
  end

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      o_sda     <= 1'b1;
      o_sda_oe  <= 1'b0;
      rst_bit_q <= 1'b1;
    end else if (i_step) begin
      o_sda_oe <= i_ctrl.tx_en;
      if (i_ctrl.restart) begin
        o_sda     <= rst_bit_q;
        rst_bit_q <= ~rst_bit_q;  // 1,0,1,0
      end else begin
        o_sda     <= i_ctrl.tx_en ? src[CMD_BITS-1] : 1'b1;
        rst_bit_q <= 1'b1;
      end
    end
  end

endmodule

/* rtl/ddr_rx_pre.sv */
// ======================================================================
// target preamble sampler
// while enabled, takes sda at the two edge strobes closing the ack
// slots; flags completion on the second one together with the abort
// level, which is that second bit
// ======================================================================
`timescale 1ns/1ps

module ddr_rx_pre (
  input  logic i_sys_clk,
  input  logic i_sys_rst,
  input  logic i_en,
  input  logic i_step,
  input  logic i_sda,
  output logic o_ack_done,
  output logic o_abort
);

  logic got_first_q;  // first preamble bit already taken

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      got_first_q <= 1'b0;
    end else if (!i_en) begin
      got_first_q <= 1'b0;
    end else if (i_step) begin
      got_first_q <= ~got_first_q;
    end
  end

  // valid on the closing strobe so the fsm can branch on that same edge
  assign o_ack_done = i_en && i_step && got_first_q;
  assign o_abort    = got_first_q && i_sda;

endmodule

/* rtl/ccc_engine_top.sv */
// ======================================================================
// i3c hdr-ddr ccc engine, controller side
// pulse i_engine_en with the ccc code on i_ccc_value to send one
// frame; completion comes back as done, semi done or err pulses
// ======================================================================
`timescale 1ns/1ps

module ccc_engine_top (
  input  logic       i_sys_clk,
  input  logic       i_sys_rst,
  input  logic       i_engine_en,
  input  logic [7:0] i_ccc_value,
  input  logic       i_sda,
  output logic       o_scl,
  output logic       o_sda,
  output logic       o_sda_oe,
  output logic       o_engine_done,
  output logic       o_engine_semi_done,
  output logic       o_engine_err
);
  import i3c_ccc_pkg::*;

  logic       scl_en;
  logic       pos_edge;
  logic       neg_edge;
  logic       step;        // any scl edge opens a slot
  logic       bit_clear;
  logic [4:0] bit_number;
  logic       ack_done;
  logic       abort;
  ccc_ctrl_t  ctrl;
  ddr_word_t  tx_word;

  assign step = pos_edge | neg_edge;

  scl_edge_gen u_scl_gen (
    .i_sys_clk (i_sys_clk),
    .i_sys_rst (i_sys_rst),
    .i_en      (scl_en),
    .o_scl     (o_scl),
    .o_pos_edge(pos_edge),
    .o_neg_edge(neg_edge)
  );

  ddr_bit_cnt u_bit_cnt (
    .i_sys_clk   (i_sys_clk),
    .i_sys_rst   (i_sys_rst),
    .i_clear     (bit_clear),
    .i_step      (step),
    .o_bit_number(bit_number)
  );

  ccc_handler u_handler (
    .i_sys_clk         (i_sys_clk),
    .i_sys_rst         (i_sys_rst),
    .i_engine_en       (i_engine_en),
    .i_ccc_value       (i_ccc_value),
    .i_step            (step),
    .i_bit_number      (bit_number),
    .i_ack_done        (ack_done),
    .i_abort           (abort),
    .o_scl_en          (scl_en),
    .o_bit_clear       (bit_clear),
    .o_ctrl            (ctrl),
    .o_tx_word         (tx_word),
    .o_engine_done     (o_engine_done),
    .o_engine_semi_done(o_engine_semi_done),
    .o_engine_err      (o_engine_err)
  );

  ddr_tx_ser u_tx_ser (
    .i_sys_clk(i_sys_clk),
    .i_sys_rst(i_sys_rst),
    .i_ctrl   (ctrl),
    .i_word   (tx_word),
    .i_step   (step),
    .o_sda    (o_sda),
    .o_sda_oe (o_sda_oe)
  );

  ddr_rx_pre u_rx_pre (
    .i_sys_clk (i_sys_clk),
    .i_sys_rst (i_sys_rst),
    .i_en      (ctrl.rx_en),
    .i_step    (step),
    .i_sda     (i_sda),
    .o_ack_done(ack_done),
    .o_abort   (abort)
  );

endmodule

/* dv/ccc_engine_tb.sv */
// ======================================================================
// testbench for the i3c hdr-ddr ccc engine
// runs a table of ccc frames, plays the target ack preamble on i_sda,
// decodes sda at every scl toggle and checks the stream and the
// completion pulses against words built from the frame rules
// ======================================================================
`timescale 1ns/1ps

module ccc_engine_tb;
  import i3c_ccc_pkg::*;

  localparam int CLK_PERIOD      = 20;
  localparam int NUM_ENTRIES     = 23;
  localparam int FRAME_LIMIT     = 60 * SCL_DIV;                   // cycles per frame
  localparam int WATCHDOG_CYCLES = FRAME_LIMIT * NUM_ENTRIES + 2000;

  typedef struct packed {
    logic [7:0] code;
    logic [1:0] ack_pre;     // [1] first, [0] second preamble bit
    logic       exp_direct;
    logic       busy_pulse;  // second start in the middle of the frame
    logic       rand_code;   // code replaced by a random unlisted one
  } tb_entry_t;

  logic       i_sys_clk;
  logic       i_sys_rst;
  logic       i_engine_en;
  logic [7:0] i_ccc_value;
  logic       i_sda;
  logic       o_scl;
  logic       o_sda;
  logic       o_sda_oe;
  logic       o_engine_done;
  logic       o_engine_semi_done;
  logic       o_engine_err;

  tb_entry_t   tbl [NUM_ENTRIES];
  logic        got_q[$];    // sda bits seen on the bus
  logic        exp_q[$];    // sda bits from the frame rules
  int          slot_cnt;    // scl toggles since start
  int          pulse_slot;  // scl toggles seen when the completion pulse shows
  int          n_done;
  int          n_semi;
  int          n_err_pulse;
  int          check_count;
  int          error_count;
  int          cur_idx;
  logic [1:0]  cur_ack;
  logic        sda_next;    // target level for the next drive point
  logic        scl_prev;
  logic        rec_pending;
  logic [31:0] rng_state;

  ccc_engine_top u_dut (
    .i_sys_clk         (i_sys_clk),
    .i_sys_rst         (i_sys_rst),
    .i_engine_en       (i_engine_en),
    .i_ccc_value       (i_ccc_value),
    .i_sda             (i_sda),
    .o_scl             (o_scl),
    .o_sda             (o_sda),
    .o_sda_oe          (o_sda_oe),
    .o_engine_done     (o_engine_done),
    .o_engine_semi_done(o_engine_semi_done),
    .o_engine_err      (o_engine_err)
  );

  initial begin
    i_sys_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_sys_clk = ~i_sys_clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // the thirteen required codes plus the dummy code
  function automatic logic is_listed(input logic [7:0] code);
    case (code)
      8'h00, 8'h01, 8'h09, 8'h0A, 8'h2A, 8'h1F: return 1'b1;
      8'h80, 8'h81, 8'h89, 8'h8A, 8'h8B, 8'h8C, 8'h9A, 8'h90: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic tb_entry_t make_entry(input logic [7:0] code, input logic [1:0] ack,
                                           input logic dir, input logic busy,
                                           input logic rnd);
    tb_entry_t e;
    e.code       = code;
    e.ack_pre    = ack;
    e.exp_direct = dir;
    e.busy_pulse = busy;
    e.rand_code  = rnd;
    return e;
  endfunction

  task automatic fill_table();
    tbl[0]  = make_entry(8'h00, 2'b10, 1'b0, 1'b0, 1'b0);  // broadcast set
    tbl[1]  = make_entry(8'h01, 2'b10, 1'b0, 1'b0, 1'b0);
    tbl[2]  = make_entry(8'h09, 2'b10, 1'b0, 1'b0, 1'b0);
    tbl[3]  = make_entry(8'h0A, 2'b10, 1'b0, 1'b0, 1'b0);
    tbl[4]  = make_entry(8'h2A, 2'b10, 1'b0, 1'b0, 1'b0);
    tbl[5]  = make_entry(8'h1F, 2'b10, 1'b0, 1'b0, 1'b0);  // dummy
    tbl[6]  = make_entry(8'h80, 2'b10, 1'b1, 1'b0, 1'b0);  // direct set
    tbl[7]  = make_entry(8'h81, 2'b10, 1'b1, 1'b0, 1'b0);
    tbl[8]  = make_entry(8'h89, 2'b10, 1'b1, 1'b0, 1'b0);
    tbl[9]  = make_entry(8'h8A, 2'b10, 1'b1, 1'b0, 1'b0);
    tbl[10] = make_entry(8'h8B, 2'b10, 1'b1, 1'b0, 1'b0);
    tbl[11] = make_entry(8'h8C, 2'b10, 1'b1, 1'b0, 1'b0);
    tbl[12] = make_entry(8'h9A, 2'b10, 1'b1, 1'b0, 1'b0);
    tbl[13] = make_entry(8'h90, 2'b10, 1'b1, 1'b0, 1'b0);
    tbl[14] = make_entry(8'h8B, 2'b11, 1'b1, 1'b0, 1'b0);  // abort on a direct code
    tbl[15] = make_entry(8'h09, 2'b10, 1'b0, 1'b0, 1'b0);  // recovery frame
    tbl[16] = make_entry(8'h00, 2'b01, 1'b0, 1'b0, 1'b0);  // abort, first bit 0
    tbl[17] = make_entry(8'h80, 2'b10, 1'b1, 1'b0, 1'b0);
    tbl[18] = make_entry(8'h00, 2'b10, 1'b0, 1'b0, 1'b1);  // random unlisted
    tbl[19] = make_entry(8'h00, 2'b10, 1'b0, 1'b0, 1'b1);
    tbl[20] = make_entry(8'h00, 2'b10, 1'b0, 1'b0, 1'b1);
    tbl[21] = make_entry(8'h2A, 2'b10, 1'b0, 1'b1, 1'b0);  // start while busy
    tbl[22] = make_entry(8'h90, 2'b10, 1'b1, 1'b1, 1'b0);
  endtask

  task automatic pick_unlisted_code(output logic [7:0] code);
    code = 8'h00;
    while (is_listed(code)) begin
      rng_state = xorshift32(rng_state);
      code      = rng_state[7:0];
    end
  endtask

  task automatic compare_values(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("MISMATCH %s (entry %0d) got 0x%0h expected 0x%0h at %0t",
               name, cur_idx, got, exp, $time);
    end
  endtask

  // payload msb first, then xor of odd bits and inverted xor of even bits
  task automatic push_word(input logic [15:0] w, input logic cmd);
    logic p_odd;
    logic p_even;
    p_odd  = 1'b0;
    p_even = 1'b0;
    for (int i = 15; i >= 1; i -= 2) p_odd ^= w[i];
    for (int i = 14; i >= 0; i -= 2) p_even ^= w[i];
    if (cmd) begin
      exp_q.push_back(1'b0);  // command preamble 01
      exp_q.push_back(1'b1);
    end
    for (int i = 15; i >= 0; i--) exp_q.push_back(w[i]);
    exp_q.push_back(p_odd);
    exp_q.push_back(~p_even);
  endtask

  task automatic build_expected(input logic [7:0] code, input logic direct,
                                input logic abort);
    exp_q.delete();
    push_word({1'b0, 7'h00, BCAST_ADDR, 1'b0}, 1'b1);  // rnw 0, reserved, 7E, adjust 0
    if (!abort) begin
      push_word({code, 8'h00}, 1'b0);                 // no defining byte
      if (direct) begin
        for (int i = 0; i < RESTART_BITS; i++) exp_q.push_back(~i[0]);  // 1,0,1,0
      end
    end
  endtask

  // sda driver, target preamble lands 2 ns after the clock edge
  always @(posedge i_sys_clk) begin
    #2;
    i_sda = sda_next;
  end

  // bus monitor on the falling clock edge, away from any update
  always @(negedge i_sys_clk) begin
    if (!i_sys_rst) begin
      scl_prev    = 1'b1;
      rec_pending = 1'b0;
    end else begin
      if (rec_pending) begin
        if (o_sda_oe) got_q.push_back(o_sda);  // bit settles one cycle after toggle
        rec_pending = 1'b0;
      end
      if (o_scl !== scl_prev) begin
        rec_pending = 1'b1;
        slot_cnt++;
        if (slot_cnt == CMD_BITS + 1) sda_next = cur_ack[1];
        else if (slot_cnt == CMD_BITS + 2) sda_next = cur_ack[0];
        else sda_next = 1'b1;  // released bus
      end
      scl_prev = o_scl;
      if (o_engine_done) n_done++;
      if (o_engine_semi_done) n_semi++;
      if (o_engine_err) n_err_pulse++;
      if (o_engine_done || o_engine_semi_done || o_engine_err) pulse_slot = slot_cnt;
    end
  end

  task automatic run_entry(input int idx, input tb_entry_t ent);
    logic [7:0]  code;
    logic        abort;
    logic [63:0] got_vec;
    logic [63:0] exp_vec;
    int          cycles;
    int          exp_slots;
    cur_idx = idx;
    code    = ent.code;
    abort   = ent.ack_pre[0];
    if (ent.rand_code) pick_unlisted_code(code);
    build_expected(code, ent.exp_direct, abort);
    exp_slots = CMD_BITS + ACK_BITS + 1;  // plus the strobe closing the last slot
    if (!abort) exp_slots += DATA_BITS;
    if (!abort && ent.exp_direct) exp_slots += RESTART_BITS;
    got_q.delete();
    n_done      = 0;
    n_semi      = 0;
    n_err_pulse = 0;
    pulse_slot  = 0;
    slot_cnt    = 0;
    cur_ack     = ent.ack_pre;
    @(posedge i_sys_clk);
    #2;
    i_engine_en = 1'b1;
    i_ccc_value = code;
    @(posedge i_sys_clk);
    #2;
    i_engine_en = 1'b0;
    if (ent.busy_pulse) begin
      repeat (30) @(posedge i_sys_clk);
      #2;
      i_engine_en = 1'b1;
      i_ccc_value = code ^ 8'h5A;  // must not reach the frame
      @(posedge i_sys_clk);
      #2;
      i_engine_en = 1'b0;
    end
    cycles = 0;
    while ((n_done + n_semi + n_err_pulse) == 0 && cycles < FRAME_LIMIT) begin
      @(posedge i_sys_clk);
      cycles++;
    end
    if (cycles >= FRAME_LIMIT) begin
      error_count++;
      $display("entry %0d with code 0x%0h gave no completion pulse in %0d cycles",
               idx, code, FRAME_LIMIT);
    end
    repeat (4 * SCL_DIV) @(posedge i_sys_clk);  // catch stray pulses
    got_vec = '0;
    exp_vec = '0;
    for (int i = 0; i < got_q.size(); i++) got_vec = {got_vec[62:0], got_q[i]};
    for (int i = 0; i < exp_q.size(); i++) exp_vec = {exp_vec[62:0], exp_q[i]};
    compare_values("sda bit count", got_q.size(), exp_q.size());
    compare_values("sda stream", got_vec, exp_vec);
    compare_values("o_engine_done pulses", n_done, !abort && !ent.exp_direct);
    compare_values("o_engine_semi_done pulses", n_semi, !abort && ent.exp_direct);
    compare_values("o_engine_err pulses", n_err_pulse, abort);
    compare_values("scl toggles at completion pulse", pulse_slot, exp_slots);
    compare_values("o_scl parked", o_scl, 1'b1);
    compare_values("o_sda_oe parked", o_sda_oe, 1'b0);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge i_sys_clk);
    $display("watchdog expired, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    i_sys_rst   = 1'b0;
    i_engine_en = 1'b0;
    i_ccc_value = 8'h00;
    i_sda       = 1'b1;
    sda_next    = 1'b1;
    scl_prev    = 1'b1;
    rec_pending = 1'b0;
    slot_cnt    = 0;
    pulse_slot  = 0;
    cur_ack     = 2'b10;
    cur_idx     = -1;
    n_done      = 0;
    n_semi      = 0;
    n_err_pulse = 0;
    check_count = 0;
    error_count = 0;
    rng_state   = 32'd96811;
    fill_table();
    repeat (4) @(posedge i_sys_clk);
    #2;
    i_sys_rst = 1'b1;
    repeat (3) @(posedge i_sys_clk);
    compare_values("o_scl after reset", o_scl, 1'b1);
    compare_values("o_sda after reset", o_sda, 1'b1);
    compare_values("o_sda_oe after reset", o_sda_oe, 1'b0);
    compare_values("pulses before first start", n_done + n_semi + n_err_pulse, 0);
    for (int k = 0; k < NUM_ENTRIES; k++) run_entry(k, tbl[k]);
    $display("summary %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* tb.f */
rtl/i3c_ccc_pkg.sv
rtl/scl_edge_gen.sv
rtl/ddr_bit_cnt.sv
rtl/ccc_handler.sv
rtl/ddr_tx_ser.sv
rtl/ddr_rx_pre.sv
rtl/ccc_engine_top.sv
dv/ccc_engine_tb.sv

/* Bender.yml */
package:
  name: i3c_ccc_engine

sources:
  - rtl/i3c_ccc_pkg.sv
  - rtl/scl_edge_gen.sv
  - rtl/ddr_bit_cnt.sv
  - rtl/ccc_handler.sv
  - rtl/ddr_tx_ser.sv
  - rtl/ddr_rx_pre.sv
  - rtl/ccc_engine_top.sv
  - target: test
    files:
      - dv/ccc_engine_tb.sv
